// ==== vlog.f ====
verilog/ctrl_pkg.sv
verilog/inst_fifo.sv
verilog/decoder.sv
verilog/rename_map.sv
verilog/reorder_buffer.sv
verilog/ctrl_block.sv
verif/tb_ctrl_block.sv

// ==== verif/tb_ctrl_block.sv ====
`timescale 1ns/10ps

module tb_ctrl_block;

    localparam int FIFO_DEPTH = 8;
    localparam int PHYS_REGS  = 64;
    localparam int ROB_DEPTH  = 16;
    localparam int ROB_W      = $clog2(ROB_DEPTH);
    localparam int AREGS      = ctrl_pkg::ARCH_REGS;
    localparam logic [31:0] PC_BASE = 32'h0000_1000;

    localparam int N_STREAM = 120;
    localparam int N_BP     = 48;
    localparam int N_SQ     = 64;
    localparam int N_INST   = N_STREAM + N_BP + N_SQ;
    localparam int BP_HOLD  = 10;
    // roughly eight cycles per instruction plus reset and the full-ROB hold
    localparam int TEST_CYCLES = 10 + 8 * N_INST + BP_HOLD;
    localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

    logic                   clk;
    logic                   i_arst_n;
    logic                   i_inst_vld;
    ctrl_pkg::fetch_entry_t i_inst;
    logic                   o_stall;
    logic                   o_disp_vld;
    ctrl_pkg::disp_info_t   o_disp;
    logic                   i_wb_vld;
    logic [ROB_W-1:0]       i_wb_rob_idx;
    logic                   o_commit_vld;
    logic [31:0]            o_commit_pc;
    logic                   o_squash_vld;
    logic [31:0]            o_squash_pc;

    // expected decode of each generated instruction in fetch order
    ctrl_pkg::op_class_t op_tab    [N_INST];
    logic [4:0]          rd_tab    [N_INST];
    logic [4:0]          rs1_tab   [N_INST];
    logic [4:0]          rs2_tab   [N_INST];
    logic                use1_tab  [N_INST];
    logic                use2_tab  [N_INST];
    logic                hasrd_tab [N_INST];
    int                  prd_tab   [N_INST];

    // scoreboard
    logic [31:0] disp_q   [$];
    logic [31:0] commit_q [$];
    int          wb_idx   [$];
    int          wb_ready [$];
    int          spec_map [AREGS];
    int          cmt_map  [AREGS];
    logic        owned    [PHYS_REGS];
    int          inflight;
    int          alloc_ptr;
    int          commits;
    int          squashes;
    logic        first_rd_disp;
    logic [31:0] exp_pc;
    int          k;

    // stimulus control
    logic [31:0] lcg_state;
    logic [31:0] gap;
    int          fetch_left;
    int          ill_period;
    int          gen_count;
    logic        wb_enable;
    logic        taken;
    logic        fired;
    int          pick;
    int          cycle;
    int          timeout_cnt;
    logic        reset_window;

    // reporting
    int checks;
    int errors;
    int n_tests;
    int n_failed;
    int mark;
    int c0;
    int s0;

    ctrl_block #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) i_ctrl_block (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_inst_vld  (i_inst_vld),
        .i_inst      (i_inst),
        .o_stall     (o_stall),
        .o_disp_vld  (o_disp_vld),
        .o_disp      (o_disp),
        .i_wb_vld    (i_wb_vld),
        .i_wb_rob_idx(i_wb_rob_idx),
        .o_commit_vld(o_commit_vld),
        .o_commit_pc (o_commit_pc),
        .o_squash_vld(o_squash_vld),
        .o_squash_pc (o_squash_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int slot(input logic [31:0] pc);
        return int'((pc - PC_BASE) >> 2);
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("error at time %0t: %s", $time, what);
        end
    endtask

    // outputs are stable a little after the falling edge
    task automatic settle_cycle();
        @(negedge clk);
        #1;
    endtask

    task automatic wait_drained();
        settle_cycle();
        while (fetch_left > 0 || i_inst_vld || disp_q.size() != 0 || commit_q.size() != 0) begin
            settle_cycle();
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        n_tests++;
        if (errors != err_mark) begin
            n_failed++;
        end
        $display("test %s: %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
    endtask

    task automatic present_next();
        logic [31:0] r;
        logic [31:0] s;
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] word;
        r = next_rand();
        s = next_rand();
        kind = int'(r[17:16]) % 3;
        if (ill_period != 0 && (gen_count % ill_period) == ill_period - 1) begin
            kind = 3;
        end
        // mostly low registers so that dependences are common
        rd  = r[21] ? r[26:22] : {2'b00, r[20:18]};
        rs1 = {2'b00, r[29:27]};
        rs2 = {2'b00, s[30:28]};
        f3  = s[2:0];
        f7  = (s[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
        imm = s[19:8];
        // shift immediates carry only the funct7 pattern up top
        if (f3 == 3'd1) begin
            imm[11:5] = 7'b0000000;
        end
        if (f3 == 3'd5) begin
            imm[11:5] = f7;
        end
        case (kind)
            0: begin
                word = {f7, rs2, rs1, f3, rd, ctrl_pkg::OPC_OP};
                op_tab[gen_count] = ctrl_pkg::op_alu_reg;
            end
            1: begin
                word = {imm, rs1, f3, rd, ctrl_pkg::OPC_OP_IMM};
                op_tab[gen_count] = ctrl_pkg::op_alu_imm;
            end
            2: begin
                word = {s[31:12], rd, ctrl_pkg::OPC_LUI};
                op_tab[gen_count] = ctrl_pkg::op_lui;
            end
            default: begin
                // load opcode lies outside the decoded set
                word = {s[31:7], 7'b0000011};
                op_tab[gen_count] = ctrl_pkg::op_illegal;
            end
        endcase
        rd_tab[gen_count]    = rd;
        rs1_tab[gen_count]   = rs1;
        rs2_tab[gen_count]   = rs2;
        use1_tab[gen_count]  = (kind < 2);
        use2_tab[gen_count]  = (kind == 0);
        hasrd_tab[gen_count] = (kind != 3) && (rd != 5'd0);
        i_inst_vld <= 1'b1;
        i_inst.pc  <= PC_BASE + 32'(4 * gen_count);
        i_inst.inst <= word;
        gen_count++;
        fetch_left--;
    endtask

    // fetch source and execution units
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!i_arst_n) begin
            i_inst_vld <= 1'b0;
            i_wb_vld   <= 1'b0;
        end else begin
            if (!i_inst_vld || taken) begin
                gap = next_rand();
                if (fetch_left > 0 && gap[18:16] != 3'd0) begin
                    present_next();
                end else begin
                    i_inst_vld <= 1'b0;
                end
            end
            fired = 1'b0;
            if (wb_enable && wb_idx.size() > 0) begin
                pick = (next_rand() >> 16) % wb_idx.size();
                if (wb_ready[pick] <= cycle) begin
                    i_wb_vld     <= 1'b1;
                    i_wb_rob_idx <= ROB_W'(wb_idx[pick]);
                    wb_idx.delete(pick);
                    wb_ready.delete(pick);
                    fired = 1'b1;
                end
            end
            if (!fired) begin
                i_wb_vld <= 1'b0;
            end
        end
    end

    // output monitor and scoreboard
    always @(negedge clk) begin
        if (reset_window) begin
            expect_equal("o_disp_vld", o_disp_vld, 0);
            expect_equal("o_commit_vld", o_commit_vld, 0);
            expect_equal("o_squash_vld", o_squash_vld, 0);
            expect_equal("o_stall", o_stall, 0);
        end
        taken = i_arst_n && i_inst_vld && !o_stall;
        if (i_arst_n && o_disp_vld) begin
            confirm(disp_q.size() > 0, "dispatch with no accepted instruction waiting");
            confirm(inflight < ROB_DEPTH, "dispatch while the ROB already holds ROB_DEPTH entries");
            if (disp_q.size() > 0) begin
                exp_pc = disp_q.pop_front();
                k = slot(exp_pc);
                expect_equal("o_disp.pc", o_disp.pc, exp_pc);
                expect_equal("o_disp.op", o_disp.op, op_tab[k]);
                expect_equal("o_disp.has_rd", o_disp.has_rd, hasrd_tab[k]);
                expect_equal("o_disp.rob_idx", o_disp.rob_idx, alloc_ptr);
                if (use1_tab[k]) begin
                    expect_equal("o_disp.prs1", o_disp.prs1, spec_map[rs1_tab[k]]);
                end
                if (use2_tab[k]) begin
                    expect_equal("o_disp.prs2", o_disp.prs2, spec_map[rs2_tab[k]]);
                end
                if (hasrd_tab[k]) begin
                    if (first_rd_disp) begin
                        expect_equal("first o_disp.prd", o_disp.prd, AREGS);
                        first_rd_disp = 1'b0;
                    end
                    expect_equal("o_disp.rd", o_disp.rd, rd_tab[k]);
                    expect_equal("o_disp.old_prd", o_disp.old_prd, spec_map[rd_tab[k]]);
                    confirm(o_disp.prd < PHYS_REGS, "dispatched prd beyond the register file");
                    confirm(!owned[o_disp.prd], "prd dispatched while an earlier holder is live");
                    owned[o_disp.prd] = 1'b1;
                    spec_map[rd_tab[k]] = o_disp.prd;
                    prd_tab[k] = o_disp.prd;
                end
                if (op_tab[k] != ctrl_pkg::op_illegal) begin
                    wb_idx.push_back(int'(o_disp.rob_idx));
                    wb_ready.push_back(cycle + 1 + int'((next_rand() >> 16) % 8));
                end
            end
            inflight++;
            alloc_ptr = (alloc_ptr + 1) % ROB_DEPTH;
        end
        if (i_arst_n && o_commit_vld) begin
            confirm(commit_q.size() > 0, "commit with nothing outstanding");
            if (commit_q.size() > 0) begin
                exp_pc = commit_q.pop_front();
                k = slot(exp_pc);
                expect_equal("o_commit_pc", o_commit_pc, exp_pc);
                confirm(op_tab[k] != ctrl_pkg::op_illegal, "commit for an illegal instruction");
                // the previous writer of rd is released here
                if (hasrd_tab[k]) begin
                    owned[cmt_map[rd_tab[k]]] = 1'b0;
                    cmt_map[rd_tab[k]] = prd_tab[k];
                end
            end
            inflight--;
            commits++;
        end
        if (i_arst_n && o_squash_vld) begin
            confirm(commit_q.size() > 0, "squash with nothing outstanding");
            if (commit_q.size() > 0) begin
                expect_equal("o_squash_pc", o_squash_pc, commit_q[0]);
                confirm(op_tab[slot(commit_q[0])] == ctrl_pkg::op_illegal,
                        "squash raised for a legal instruction");
            end
            // an entry accepted in the squash cycle is flushed with the rest
            commit_q.delete();
            disp_q.delete();
            wb_idx.delete();
            wb_ready.delete();
            inflight  = 0;
            alloc_ptr = 0;
            for (int p = 0; p < PHYS_REGS; p++) begin
                owned[p] = 1'b0;
            end
            for (int a = 0; a < AREGS; a++) begin
                spec_map[a] = cmt_map[a];
                owned[cmt_map[a]] = 1'b1;
            end
            squashes++;
        end else if (taken) begin
            disp_q.push_back(i_inst.pc);
            commit_q.push_back(i_inst.pc);
        end
    end

    always @(posedge clk) begin
        timeout_cnt = timeout_cnt + 1;
        if (timeout_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        i_arst_n      = 1'b0;
        i_inst_vld    = 1'b0;
        i_inst        = '0;
        i_wb_vld      = 1'b0;
        i_wb_rob_idx  = '0;
        lcg_state     = 32'hdbbd_fc17;
        fetch_left    = 0;
        ill_period    = 0;
        gen_count     = 0;
        wb_enable     = 1'b0;
        taken         = 1'b0;
        cycle         = 0;
        timeout_cnt   = 0;
        reset_window  = 1'b1;
        inflight      = 0;
        alloc_ptr     = 0;
        commits       = 0;
        squashes      = 0;
        first_rd_disp = 1'b1;
        checks        = 0;
        errors        = 0;
        n_tests       = 0;
        n_failed      = 0;
        // identity maps with x0..x31 in p0..p31
        for (int a = 0; a < AREGS; a++) begin
            spec_map[a] = a;
            cmt_map[a]  = a;
        end
        for (int p = 0; p < PHYS_REGS; p++) begin
            owned[p] = (p < AREGS);
        end

        mark = errors;
        repeat (5) @(posedge clk);
        i_arst_n <= 1'b1;
        settle_cycle();
        reset_window = 1'b0;
        report_test("reset", mark);

        // random stream with writeback in random order
        mark = errors;
        c0 = commits;
        wb_enable  = 1'b1;
        fetch_left = N_STREAM;
        wait_drained();
        expect_equal("stream commit count", commits - c0, N_STREAM);
        report_test("in_order_rename", mark);

        // writeback held back until the ROB fills
        mark = errors;
        c0 = commits;
        wb_enable  = 1'b0;
        fetch_left = N_BP;
        settle_cycle();
        while (!o_stall) begin
            settle_cycle();
        end
        repeat (BP_HOLD) begin
            settle_cycle();
            confirm(!o_disp_vld, "dispatch while the ROB is full");
            expect_equal("ROB occupancy", inflight, ROB_DEPTH);
        end
        wb_enable = 1'b1;
        wait_drained();
        expect_equal("back-pressure commit count", commits - c0, N_BP);
        report_test("back_pressure", mark);

        // every sixteenth instruction is illegal
        mark = errors;
        s0 = squashes;
        ill_period = 16;
        fetch_left = N_SQ;
        wait_drained();
        ill_period = 0;
        confirm(squashes > s0, "no squash seen for an illegal instruction");
        repeat (5) settle_cycle();
        report_test("squash", mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/ctrl_block.sv ====
`timescale 1ns/10ps

module ctrl_block #(
    parameter int FIFO_DEPTH = 8,
    parameter int PHYS_REGS  = 64,
    parameter int ROB_DEPTH  = 16
) (
    input  wire                               clk,
    input  wire                               i_arst_n,
    input  wire                               i_inst_vld,
    input  ctrl_pkg::fetch_entry_t            i_inst,
    output logic                              o_stall,
    output logic                              o_disp_vld,
    output ctrl_pkg::disp_info_t              o_disp,
    input  wire                               i_wb_vld,
    input  wire [$clog2(ROB_DEPTH)-1:0]       i_wb_rob_idx,
    output logic                              o_commit_vld,
    output logic [ctrl_pkg::XLEN-1:0]         o_commit_pc,
    output logic                              o_squash_vld,
    output logic [ctrl_pkg::XLEN-1:0]         o_squash_pc
);
    // fetch buffer to decode
    logic                   fifo_can_enq;
    logic                   fifo_can_deq;
    logic                   fifo_deq_req;
    ctrl_pkg::fetch_entry_t fifo_head;

    // decode to rename
    logic                   dec_vld;
    ctrl_pkg::dec_info_t    dec_info;
    logic                   rename_stall;

    // rob to rename
    logic                         rob_can_alloc;
    logic [$clog2(ROB_DEPTH)-1:0] rob_alloc_idx;
    ctrl_pkg::commit_info_t       commit_info;

    assign o_stall = !fifo_can_enq;

    inst_fifo #(
        .dtype(ctrl_pkg::fetch_entry_t),
        .DEPTH(FIFO_DEPTH)
    ) u_inst_fifo (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_flush   (o_squash_vld),
        .i_enq_vld (i_inst_vld),
        .i_enq_data(i_inst),
        .o_can_enq (fifo_can_enq),
        .o_can_deq (fifo_can_deq),
        .i_deq_req (fifo_deq_req),
        .o_deq_data(fifo_head)
    );

    decoder u_decoder (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_squash_vld(o_squash_vld),
        .i_stall     (rename_stall),
        .i_inst_vld  (fifo_can_deq),
        .i_inst      (fifo_head),
        .o_deq_req   (fifo_deq_req),
        .o_dec_vld   (dec_vld),
        .o_dec_info  (dec_info)
    );

    rename_map #(
        .PHYS_REGS(PHYS_REGS),
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rename_map (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_squash_vld   (o_squash_vld),
        .i_dec_vld      (dec_vld),
        .i_dec_info     (dec_info),
        .o_stall        (rename_stall),
        .i_rob_can_alloc(rob_can_alloc),
        .i_alloc_rob_idx(rob_alloc_idx),
        .i_commit_vld   (o_commit_vld),
        .i_commit_info  (commit_info),
        .o_disp_vld     (o_disp_vld),
        .o_disp_info    (o_disp)
    );

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_reorder_buffer (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_disp_vld    (o_disp_vld),
        .i_disp_info   (o_disp),
        .i_disp_old_prd(o_disp.old_prd),
        .i_disp_rd     (o_disp.rd),
        .o_can_alloc   (rob_can_alloc),
        .o_alloc_idx   (rob_alloc_idx),
        .i_wb_vld      (i_wb_vld),
        .i_wb_rob_idx  (i_wb_rob_idx),
        .o_commit_vld  (o_commit_vld),
        .o_commit_pc   (o_commit_pc),
        .o_commit_info (commit_info),
        .o_squash_vld  (o_squash_vld),
        .o_squash_pc   (o_squash_pc)
    );

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                                clk,
    input  wire                                i_arst_n,
    input  wire                                i_disp_vld,
    input  ctrl_pkg::disp_info_t               i_disp_info,
    input  ctrl_pkg::idx_t                     i_disp_old_prd,
    input  ctrl_pkg::areg_t                    i_disp_rd,
    output logic                               o_can_alloc,
    output logic [$clog2(ROB_DEPTH)-1:0]       o_alloc_idx,
    input  wire                                i_wb_vld,
    input  wire [$clog2(ROB_DEPTH)-1:0]        i_wb_rob_idx,
    output logic                               o_commit_vld,
    output logic [ctrl_pkg::XLEN-1:0]          o_commit_pc,
    output ctrl_pkg::commit_info_t             o_commit_info,
    output logic                               o_squash_vld,
    output logic [ctrl_pkg::XLEN-1:0]          o_squash_pc
);
    localparam int ROB_W = $clog2(ROB_DEPTH);

    logic [ctrl_pkg::XLEN-1:0] pc_q      [ROB_DEPTH];
    ctrl_pkg::areg_t           rd_q      [ROB_DEPTH];
    ctrl_pkg::idx_t            prd_q     [ROB_DEPTH];
    ctrl_pkg::idx_t            old_prd_q [ROB_DEPTH];
    logic                      has_rd_q  [ROB_DEPTH];
    logic                      ill_q     [ROB_DEPTH];
    logic                      done_q    [ROB_DEPTH];

    logic [ROB_W-1:0] head_q;
    logic [ROB_W-1:0] tail_q;
    logic [ROB_W:0]   count_q;
    logic [ROB_W:0]   occupancy;
    logic             head_vld;
    logic             is_ill;

    assign is_ill   = (i_disp_info.op == ctrl_pkg::op_illegal);
    assign head_vld = (count_q != '0);

    // rename looks one entry ahead while its strobe is still on the wire
    assign occupancy   = count_q + (ROB_W + 1)'(i_disp_vld);
    assign o_can_alloc = occupancy < (ROB_W + 1)'(ROB_DEPTH);
    assign o_alloc_idx = i_disp_vld ? tail_q + 1'b1 : tail_q;

    // a done head retires or squashes when illegal
    assign o_commit_vld = head_vld && done_q[head_q] && !ill_q[head_q];
    assign o_squash_vld = head_vld && done_q[head_q] && ill_q[head_q];
    assign o_commit_pc  = pc_q[head_q];
    assign o_squash_pc  = pc_q[head_q];

    assign o_commit_info.has_rd  = has_rd_q[head_q];
    assign o_commit_info.rd      = rd_q[head_q];
    assign o_commit_info.new_prd = prd_q[head_q];
    assign o_commit_info.old_prd = old_prd_q[head_q];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (o_squash_vld) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (i_disp_vld) begin
                tail_q <= tail_q + 1'b1;
            end
            if (o_commit_vld) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + (ROB_W + 1)'(i_disp_vld) - (ROB_W + 1)'(o_commit_vld);
        end
    end

    // entry payload whose validity comes from the pointers
    always_ff @(posedge clk) begin
        if (i_disp_vld) begin
            pc_q[tail_q]      <= i_disp_info.pc;
            rd_q[tail_q]      <= i_disp_rd;
            prd_q[tail_q]     <= i_disp_info.prd;
            old_prd_q[tail_q] <= i_disp_old_prd;
            has_rd_q[tail_q]  <= i_disp_info.has_rd;
            ill_q[tail_q]     <= is_ill;
            // nothing executes an illegal entry
            done_q[tail_q]    <= is_ill;
        end
        if (i_wb_vld) begin
            done_q[i_wb_rob_idx] <= 1'b1;
        end
    end

endmodule

// ==== verilog/rename_map.sv ====
`timescale 1ns/10ps

module rename_map #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 16
) (
    input  wire                          clk,
    input  wire                          i_arst_n,
    input  wire                          i_squash_vld,
    input  wire                          i_dec_vld,
    input  ctrl_pkg::dec_info_t          i_dec_info,
    output logic                         o_stall,
    input  wire                          i_rob_can_alloc,
    input  wire [$clog2(ROB_DEPTH)-1:0]  i_alloc_rob_idx,
    input  wire                          i_commit_vld,
    input  ctrl_pkg::commit_info_t       i_commit_info,
    output logic                         o_disp_vld,
    output ctrl_pkg::disp_info_t         o_disp_info
);
    localparam int PRD_W = $clog2(PHYS_REGS);
    localparam int AREGS = ctrl_pkg::ARCH_REGS;

    logic [PRD_W-1:0]     spec_map [AREGS];
    logic [PRD_W-1:0]     cmt_map  [AREGS];
    logic [PHYS_REGS-1:0] free_q;
    logic [PHYS_REGS-1:0] cmt_used;
    logic [PRD_W-1:0]     free_idx;
    logic                 free_any;
    logic                 need_reg;
    logic                 can_go;
    logic                 accept;
    logic                 disp_vld_q;

    // lowest free register wins
    always_comb begin
        free_any = 1'b0;
        free_idx = '0;
        for (int p = PHYS_REGS - 1; p >= 0; p--) begin
            if (free_q[p]) begin
                free_any = 1'b1;
                free_idx = PRD_W'(p);
            end
        end
    end

    // registers held by the committed state
    always_comb begin
        cmt_used = '0;
        for (int a = 0; a < AREGS; a++) begin
            cmt_used[cmt_map[a]] = 1'b1;
        end
    end

    assign need_reg   = i_dec_info.has_rd && !i_dec_info.illegal;
    assign can_go     = i_rob_can_alloc && (free_any || !need_reg);
    assign o_stall    = i_dec_vld && !can_go;
    assign accept     = i_dec_vld && can_go && !i_squash_vld;
    assign o_disp_vld = disp_vld_q && !i_squash_vld;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int a = 0; a < AREGS; a++) begin
                spec_map[a] <= PRD_W'(a);
                cmt_map[a]  <= PRD_W'(a);
            end
            for (int p = 0; p < PHYS_REGS; p++) begin
                free_q[p] <= (p >= AREGS);
            end
        end else if (i_squash_vld) begin
            // roll back to the committed state
            for (int a = 0; a < AREGS; a++) begin
                spec_map[a] <= cmt_map[a];
            end
            free_q <= ~cmt_used;
        end else begin
            if (accept && need_reg) begin
                spec_map[i_dec_info.rd] <= free_idx;
                free_q[free_idx]        <= 1'b0;
            end
            if (i_commit_vld && i_commit_info.has_rd) begin
                cmt_map[i_commit_info.rd]                <= i_commit_info.new_prd[PRD_W-1:0];
                free_q[i_commit_info.old_prd[PRD_W-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            disp_vld_q <= 1'b0;
        end else begin
            disp_vld_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_disp_info.pc      <= i_dec_info.pc;
            o_disp_info.op      <= i_dec_info.op;
            o_disp_info.rob_idx <= ctrl_pkg::idx_t'(i_alloc_rob_idx);
            o_disp_info.rd      <= i_dec_info.rd;
            o_disp_info.prd     <= need_reg ? ctrl_pkg::idx_t'(free_idx) : '0;
            o_disp_info.old_prd <= ctrl_pkg::idx_t'(spec_map[i_dec_info.rd]);
            o_disp_info.prs1    <= i_dec_info.use_rs1 ?
                                   ctrl_pkg::idx_t'(spec_map[i_dec_info.rs1]) : '0;
            o_disp_info.prs2    <= i_dec_info.use_rs2 ?
                                   ctrl_pkg::idx_t'(spec_map[i_dec_info.rs2]) : '0;
            o_disp_info.has_rd  <= need_reg;
        end
    end

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/10ps

module decoder (
    input  wire                     clk,
    input  wire                     i_arst_n,
    input  wire                     i_squash_vld,
    input  wire                     i_stall,
    input  wire                     i_inst_vld,
    input  ctrl_pkg::fetch_entry_t  i_inst,
    output logic                    o_deq_req,
    output logic                    o_dec_vld,
    output ctrl_pkg::dec_info_t     o_dec_info
);
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                advance;
    logic                dec_vld_q;
    ctrl_pkg::dec_info_t dec;

    assign opcode = i_inst.inst[6:0];
    assign funct3 = i_inst.inst[14:12];
    assign funct7 = i_inst.inst[31:25];

    // stage register frees up when empty or when rename takes it
    assign advance   = !dec_vld_q || !i_stall;
    assign o_deq_req = i_inst_vld && advance && !i_squash_vld;
    assign o_dec_vld = dec_vld_q;

    always_comb begin
        dec         = '0;
        dec.pc      = i_inst.pc;
        dec.rd      = i_inst.inst[11:7];
        dec.rs1     = i_inst.inst[19:15];
        dec.rs2     = i_inst.inst[24:20];
        dec.op      = ctrl_pkg::op_illegal;
        dec.illegal = 1'b1;
        case (opcode)
            ctrl_pkg::OPC_OP: begin
                // sub and sra are the only alternate forms
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dec.op      = ctrl_pkg::op_alu_reg;
                    dec.illegal = 1'b0;
                    dec.use_rs1 = 1'b1;
                    dec.use_rs2 = 1'b1;
                end
            end
            ctrl_pkg::OPC_OP_IMM: begin
                // shift immediates constrain the upper bits
                if ((funct3 == 3'b001 && funct7 == 7'b0000000) ||
                    (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) ||
                    (funct3 != 3'b001 && funct3 != 3'b101)) begin
                    dec.op      = ctrl_pkg::op_alu_imm;
                    dec.illegal = 1'b0;
                    dec.use_rs1 = 1'b1;
                end
            end
            ctrl_pkg::OPC_LUI: begin
                dec.op      = ctrl_pkg::op_lui;
                dec.illegal = 1'b0;
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
        // writes to x0 are dropped
        dec.has_rd = !dec.illegal && (dec.rd != '0);
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dec_vld_q <= 1'b0;
        end else if (i_squash_vld) begin
            dec_vld_q <= 1'b0;
        end else if (advance) begin
            dec_vld_q <= o_deq_req;
        end
    end

    always_ff @(posedge clk) begin
        if (o_deq_req) begin
            o_dec_info <= dec;
        end
    end

endmodule

// ==== verilog/inst_fifo.sv ====
`timescale 1ns/10ps

module inst_fifo #(
    parameter type dtype = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  wire  clk,
    input  wire  i_arst_n,
    input  wire  i_flush,
    input  wire  i_enq_vld,
    input  dtype i_enq_data,
    output logic o_can_enq,
    output logic o_can_deq,
    input  wire  i_deq_req,
    output dtype o_deq_data
);
    localparam int PTR_W = $clog2(DEPTH);

    dtype             mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             enq;
    logic             deq;

    assign o_can_deq  = (count_q != '0);
    assign deq        = i_deq_req && o_can_deq;
    // a full buffer still takes a new entry when the head leaves
    assign o_can_enq  = (count_q != (PTR_W + 1)'(DEPTH)) || deq;
    assign enq        = i_enq_vld && o_can_enq;
    assign o_deq_data = mem[rd_ptr_q];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (i_flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W + 1)'(enq) - (PTR_W + 1)'(deq);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr_q] <= i_enq_data;
        end
    end

endmodule

// ==== verilog/ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int AREG_W    = $clog2(ARCH_REGS);

    // widest physical register and rob index the structs can carry
    localparam int IDX_W = 8;

    // opcodes taken by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [IDX_W-1:0]  idx_t;

    typedef enum logic [1:0] {
        op_alu_reg,
        op_alu_imm,
        op_lui,
        op_illegal
    } op_class_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_class_t       op;
        areg_t           rd;
        areg_t           rs1;
        areg_t           rs2;
        logic            use_rs1;
        logic            use_rs2;
        logic            has_rd;
        logic            illegal;
    } dec_info_t;

    // rd and old_prd ride along for the rob
    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_class_t       op;
        idx_t            rob_idx;
        areg_t           rd;
        idx_t            prd;
        idx_t            old_prd;
        idx_t            prs1;
        idx_t            prs2;
        logic            has_rd;
    } disp_info_t;

    typedef struct packed {
        logic  has_rd;
        areg_t rd;
        idx_t  new_prd;
        idx_t  old_prd;
    } commit_info_t;

endpackage
